// File: dv/ex_stage_vectors.svh
// add_row columns: name, pc, ctrl {wb_en, mem_r_en, mem_w_en, status_w_en, branch_taken},
// immd, exe_cmd, is_mul, val_rn, val_rm, dest, signed_immd_24, shifter operand,
// status_in {n,z,c,v}, expected status_out, expected branch_address, expected alu_res
task automatic load_vectors();
	add_row("add_carry_out", 32'h0000_0100, 5'b10010, 1'b0, ex_pkg::ADD, 1'b0,
		32'hffff_ffff, 32'h0000_0001, 4'd1, 24'h000001, reg_so(5'd0, ex_pkg::LSL, 4'd2),
		4'b0000, 4'b0110, 32'h0000_0104, 32'h0000_0000);
	add_row("add_overflow", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::ADD, 1'b0,
		32'h7fff_ffff, 32'h0000_0001, 4'd2, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd3),
		4'b0000, 4'b1001, 32'h0000_1000, 32'h8000_0000);
	add_row("adc_carry_in", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::ADC, 1'b0,
		32'h0000_0010, 32'h0000_0020, 4'd3, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd4),
		4'b0010, 4'b0000, 32'h0000_1000, 32'h0000_0031);
	add_row("sub_borrow", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::SUB, 1'b0,
		32'h0000_0005, 32'h0000_0007, 4'd4, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd5),
		4'b0000, 4'b1000, 32'h0000_1000, 32'hffff_fffe);
	// compare writes flags only
	add_row("cmp_equal", 32'h0000_1000, 5'b00010, 1'b0, ex_pkg::SUB, 1'b0,
		32'h0000_1234, 32'h0000_1234, 4'd5, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd6),
		4'b1001, 4'b0110, 32'h0000_1000, 32'h0000_0000);
	add_row("sbc_no_carry", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::SBC, 1'b0,
		32'h8000_0000, 32'h0000_0001, 4'd6, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd7),
		4'b0000, 4'b0011, 32'h0000_1000, 32'h7fff_fffe);
	add_row("and_keep_cv", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::AND, 1'b0,
		32'hf0f0_f0f0, 32'h0ff0_0ff0, 4'd7, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd8),
		4'b0011, 4'b0011, 32'h0000_1000, 32'h00f0_00f0);
	// 0xab rotated right by 8
	add_row("orr_rot_immd", 32'h0000_1000, 5'b10010, 1'b1, ex_pkg::ORR, 1'b0,
		32'h0000_0001, 32'h0000_5555, 4'd8, 24'h0, imm_so(4'd4, 8'hab),
		4'b0010, 4'b1010, 32'h0000_1000, 32'hab00_0001);
	add_row("eor_zero", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::EOR, 1'b0,
		32'ha5a5_a5a5, 32'ha5a5_a5a5, 4'd9, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd9),
		4'b0001, 4'b0101, 32'h0000_1000, 32'h0000_0000);
	add_row("mov_lsl", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b0,
		32'h0000_0000, 32'h0000_00ff, 4'd10, 24'h0, reg_so(5'd4, ex_pkg::LSL, 4'd1),
		4'b0000, 4'b0000, 32'h0000_1000, 32'h0000_0ff0);
	add_row("mvn_lsr", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MVN, 1'b0,
		32'h0000_0000, 32'hf000_0000, 4'd11, 24'h0, reg_so(5'd28, ex_pkg::LSR, 4'd2),
		4'b0010, 4'b1010, 32'h0000_1000, 32'hffff_fff0);
	add_row("mov_asr", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b0,
		32'h0000_0000, 32'h8000_0000, 4'd12, 24'h0, reg_so(5'd4, ex_pkg::ASR, 4'd3),
		4'b0000, 4'b1000, 32'h0000_1000, 32'hf800_0000);
	add_row("mov_ror", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b0,
		32'h0000_0000, 32'h0000_0012, 4'd13, 24'h0, reg_so(5'd8, ex_pkg::ROR, 4'd4),
		4'b0000, 4'b0000, 32'h0000_1000, 32'h1200_0000);
	// raw field 0x804, not rotated
	add_row("ldr_offset", 32'h0000_1000, 5'b11000, 1'b0, ex_pkg::ADD, 1'b0,
		32'h0000_2000, 32'hdead_beef, 4'd14, 24'h0, imm_so(4'h8, 8'h04),
		4'b0000, 4'b0000, 32'h0000_1000, 32'h0000_2804);
	// raw field 0xfcf, not shifted
	add_row("str_offset", 32'h0000_1000, 5'b00100, 1'b0, ex_pkg::ADD, 1'b0,
		32'h0000_3000, 32'h1234_5678, 4'd15, 24'h0, reg_so(5'd31, ex_pkg::ASR, 4'hf),
		4'b0000, 4'b0000, 32'h0000_1000, 32'h0000_3fcf);
	add_row("mul_small", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b1,
		32'h0001_0003, 32'h0001_0005, 4'd1, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0),
		4'b0011, 4'b0011, 32'h0000_1000, 32'h0008_000f);
	add_row("mul_zero", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b1,
		32'h0001_0000, 32'h0001_0000, 4'd2, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0),
		4'b0000, 4'b0100, 32'h0000_1000, 32'h0000_0000);
	add_row("mul_neg", 32'h0000_1000, 5'b10010, 1'b0, ex_pkg::MOV, 1'b1,
		32'hffff_ffff, 32'h0000_0002, 4'd3, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0),
		4'b0010, 4'b1010, 32'h0000_1000, 32'hffff_fffe);
	add_row("branch_fwd", 32'h0000_1000, 5'b00001, 1'b0, ex_pkg::MOV, 1'b0,
		32'h0000_0000, 32'h0000_0000, 4'd0, 24'h000010, reg_so(5'd0, ex_pkg::LSL, 4'd0),
		4'b0000, 4'b0100, 32'h0000_1040, 32'h0000_0000);
	add_row("branch_back", 32'h0000_2000, 5'b00001, 1'b0, ex_pkg::MOV, 1'b0,
		32'h0000_0000, 32'h0000_0000, 4'd0, 24'hff_fffe, reg_so(5'd0, ex_pkg::LSL, 4'd0),
		4'b0000, 4'b0100, 32'h0000_1ff8, 32'h0000_0000);
endtask

// File: dv/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

	localparam int RESET_CYCLES = 3;

	logic                               clk;
	logic                               reset;
	ex_pkg::id_ex_t                     id_ex;
	ex_pkg::status_t                    status_in;
	ex_pkg::ex_mem_t                    ex_mem;
	ex_pkg::status_t                    status_out;
	logic                               status_w_en;
	logic [ex_pkg::ADDRESS_LEN-1:0]     branch_address;
	logic                               hazard_wb_en;
	logic [ex_pkg::REG_ADDRESS_LEN-1:0] hazard_dest;

	// one entry per table row
	string                          name_q[$];
	ex_pkg::id_ex_t                 stim_q[$];
	ex_pkg::status_t                status_in_q[$];
	ex_pkg::status_t                exp_status_q[$];
	logic [ex_pkg::ADDRESS_LEN-1:0] exp_addr_q[$];
	ex_pkg::ex_mem_t                exp_mem_q[$];

	integer seed = 83941;
	integer cycle_count = 0;
	integer cycle_limit = 0;

	ex_stage UUT (
		.clk            (clk),
		.reset          (reset),
		.id_ex          (id_ex),
		.status_in      (status_in),
		.ex_mem         (ex_mem),
		.status_out     (status_out),
		.status_w_en    (status_w_en),
		.branch_address (branch_address),
		.hazard_wb_en   (hazard_wb_en),
		.hazard_dest    (hazard_dest)
	);

	always #20 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_ex_mem(input string name, input ex_pkg::ex_mem_t expected,
		input ex_pkg::ex_mem_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("error: %s ex_mem expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_status(input string name, input ex_pkg::status_t expected,
		input ex_pkg::status_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("error: %s nzcv expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic check_address(input string name,
		input logic [ex_pkg::ADDRESS_LEN-1:0] expected,
		input logic [ex_pkg::ADDRESS_LEN-1:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("error: %s address expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("error: %s expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic check_dest(input string name,
		input logic [ex_pkg::REG_ADDRESS_LEN-1:0] expected,
		input logic [ex_pkg::REG_ADDRESS_LEN-1:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	function automatic ex_pkg::shifter_operand_u reg_so(input logic [4:0] shift_imm,
		input ex_pkg::shift_t shift, input logic [3:0] rm);
		ex_pkg::shifter_operand_u so;
		so.reg_form.shift_imm = shift_imm;
		so.reg_form.shift = shift;
		so.reg_form.zero = 1'b0;
		so.reg_form.rm = rm;
		return so;
	endfunction

	function automatic ex_pkg::shifter_operand_u imm_so(input logic [3:0] rotate_imm,
		input logic [7:0] imm8);
		ex_pkg::shifter_operand_u so;
		so.imm_form.rotate_imm = rotate_imm;
		so.imm_form.imm8 = imm8;
		return so;
	endfunction

	task automatic add_row(
		input string                          name,
		input logic [ex_pkg::ADDRESS_LEN-1:0] pc,
		input logic [4:0]                     ctrl,
		input logic                           immd,
		input ex_pkg::exe_cmd_t               exe_cmd,
		input logic                           is_mul,
		input logic [31:0]                    val_rn,
		input logic [31:0]                    val_rm,
		input logic [3:0]                     dest,
		input logic [23:0]                    offset,
		input ex_pkg::shifter_operand_u       so,
		input ex_pkg::status_t                status,
		input ex_pkg::status_t                exp_status,
		input logic [ex_pkg::ADDRESS_LEN-1:0] exp_addr,
		input logic [31:0]                    exp_alu
	);
		ex_pkg::id_ex_t  stim;
		ex_pkg::ex_mem_t exp_mem;
		stim.pc = pc;
		stim.ctrl = ctrl;
		stim.immd = immd;
		stim.exe_cmd = exe_cmd;
		stim.is_mul = is_mul;
		stim.val_rn = val_rn;
		stim.val_rm = val_rm;
		stim.dest = dest;
		stim.signed_immd_24 = offset;
		stim.shift_operand = so;
		// control, val_rm and dest ride along unchanged
		exp_mem.wb_en = ctrl[4];
		exp_mem.mem_r_en = ctrl[3];
		exp_mem.mem_w_en = ctrl[2];
		exp_mem.branch_taken = ctrl[0];
		exp_mem.alu_res = exp_alu;
		exp_mem.val_rm = val_rm;
		exp_mem.dest = dest;
		name_q.push_back(name);
		stim_q.push_back(stim);
		status_in_q.push_back(status);
		exp_status_q.push_back(exp_status);
		exp_addr_q.push_back(exp_addr);
		exp_mem_q.push_back(exp_mem);
	endtask

	`include "ex_stage_vectors.svh"

	task automatic add_random_rows();
		logic [31:0]     rn;
		logic [31:0]     rm;
		logic [31:0]     res;
		logic [32:0]     sum;
		ex_pkg::status_t sin;
		ex_pkg::status_t sout;
		// add with an unshifted register
		rn = $random(seed);
		rm = $random(seed);
		sin = $random(seed);
		sum = {1'b0, rn} + {1'b0, rm};
		res = sum[31:0];
		sout = {res[31], (res == 32'h0), sum[32], ((rn[31] == rm[31]) && (res[31] != rn[31]))};
		add_row("rand_add", 32'h0000_4000, 5'b10010, 1'b0, ex_pkg::ADD, 1'b0, rn, rm,
			4'd8, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0), sin, sout, 32'h0000_4000, res);
		// eor keeps c and v
		rn = $random(seed);
		rm = $random(seed);
		sin = $random(seed);
		res = rn ^ rm;
		sout = {res[31], (res == 32'h0), sin.c, sin.v};
		add_row("rand_eor", 32'h0000_4004, 5'b10010, 1'b0, ex_pkg::EOR, 1'b0, rn, rm,
			4'd9, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0), sin, sout, 32'h0000_4004, res);
		rn = $random(seed);
		rm = $random(seed);
		sin = $random(seed);
		res = rn * rm;
		sout = {res[31], (res == 32'h0), sin.c, sin.v};
		add_row("rand_mul", 32'h0000_4008, 5'b10010, 1'b0, ex_pkg::MOV, 1'b1, rn, rm,
			4'd10, 24'h0, reg_so(5'd0, ex_pkg::LSL, 4'd0), sin, sout, 32'h0000_4008, res);
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			fail_run("timeout: the run went past its cycle limit");
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		id_ex = '0;
		status_in = '0;
		load_vectors();
		add_random_rows();
		// a live instruction while reset is held, so the clear has something to override
		id_ex = stim_q[0];
		status_in = status_in_q[0];
		cycle_limit = name_q.size() + RESET_CYCLES + 10;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_ex_mem("after_reset", '0, ex_mem);
		for (int i = 0; i < name_q.size(); i++) begin
			if (i > 0) begin
				@(negedge clk);
				check_ex_mem(name_q[i-1], exp_mem_q[i-1], ex_mem);
			end
			id_ex = stim_q[i];
			status_in = status_in_q[i];
			#1;
			check_status(name_q[i], exp_status_q[i], status_out);
			check_address(name_q[i], exp_addr_q[i], branch_address);
			check_bit({name_q[i], " status_w_en"}, stim_q[i].ctrl.status_w_en, status_w_en);
			check_bit({name_q[i], " hazard_wb_en"}, stim_q[i].ctrl.wb_en, hazard_wb_en);
			check_dest({name_q[i], " hazard_dest"}, stim_q[i].dest, hazard_dest);
		end
		@(negedge clk);
		check_ex_mem(name_q[name_q.size()-1], exp_mem_q[exp_mem_q.size()-1], ex_mem);
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+dv
hw/ex_pkg.sv
hw/operand2_gen.sv
hw/ex_alu.sv
hw/exec_unit.sv
hw/ex_mem_reg.sv
hw/ex_stage.sv
dv/ex_stage_tb.sv

// File: hw/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::exe_cmd_t                exe_cmd,
	input  logic [ex_pkg::REGISTER_LEN-1:0] a,
	input  logic [ex_pkg::REGISTER_LEN-1:0] b,
	input  ex_pkg::status_t                 status_in,
	output logic [ex_pkg::REGISTER_LEN-1:0] result,
	output ex_pkg::status_t                 status_out
);

	localparam int MSB = ex_pkg::REGISTER_LEN - 1;

	logic [ex_pkg::REGISTER_LEN:0]   sum;
	logic [ex_pkg::REGISTER_LEN-1:0] addend;
	logic                            carry_in;
	logic                            is_arith;
	logic                            is_sub;

	// classify the command
	always_comb begin
		is_arith = 1'b0;
		is_sub = 1'b0;
		carry_in = 1'b0;
		case (exe_cmd)
			ex_pkg::ADD: begin
				is_arith = 1'b1;
			end
			ex_pkg::ADC: begin
				is_arith = 1'b1;
				carry_in = status_in.c;
			end
			ex_pkg::SUB: begin
				is_arith = 1'b1;
				is_sub = 1'b1;
				carry_in = 1'b1;
			end
			ex_pkg::SBC: begin
				// a - b - !c == a + ~b + c
				is_arith = 1'b1;
				is_sub = 1'b1;
				carry_in = status_in.c;
			end
			default: begin
				is_arith = 1'b0;
			end
		endcase
	end

	assign addend = is_sub ? ~b : b;

	// 33 bits so the carry falls out on top
	assign sum = {1'b0, a} + {1'b0, addend} + {{ex_pkg::REGISTER_LEN{1'b0}}, carry_in};

	always_comb begin
		case (exe_cmd)
			ex_pkg::MOV: begin
				result = b;
			end
			ex_pkg::MVN: begin
				result = ~b;
			end
			ex_pkg::AND: begin
				result = a & b;
			end
			ex_pkg::ORR: begin
				result = a | b;
			end
			ex_pkg::EOR: begin
				result = a ^ b;
			end
			ex_pkg::ADD, ex_pkg::ADC, ex_pkg::SUB, ex_pkg::SBC: begin
				result = sum[MSB:0];
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_comb begin
		status_out.n = result[MSB];
		status_out.z = (result == '0);
		if (is_arith) begin
			// carry out, which is not-borrow on the subtract side
			status_out.c = sum[ex_pkg::REGISTER_LEN];
			status_out.v = (a[MSB] == addend[MSB]) && (result[MSB] != a[MSB]);
		end else begin
			status_out.c = status_in.c;
			status_out.v = status_in.v;
		end
	end

endmodule

// File: hw/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg (
	input  logic            clk,
	input  logic            reset,
	input  ex_pkg::ex_mem_t ex_next,
	output ex_pkg::ex_mem_t ex_mem
);

	// no stall or flush, loads every cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.wb_en <= 1'b0;
			ex_mem.mem_r_en <= 1'b0;
			ex_mem.mem_w_en <= 1'b0;
			ex_mem.branch_taken <= 1'b0;
			ex_mem.alu_res <= '0;
			ex_mem.val_rm <= '0;
			ex_mem.dest <= '0;
		end else begin
			ex_mem.wb_en <= ex_next.wb_en;
			ex_mem.mem_r_en <= ex_next.mem_r_en;
			ex_mem.mem_w_en <= ex_next.mem_w_en;
			ex_mem.branch_taken <= ex_next.branch_taken;
			ex_mem.alu_res <= ex_next.alu_res;
			ex_mem.val_rm <= ex_next.val_rm;
			ex_mem.dest <= ex_next.dest;
		end
	end

endmodule

// File: hw/ex_pkg.sv
package ex_pkg;

	localparam int ADDRESS_LEN     = 32;
	localparam int REGISTER_LEN    = 32;
	localparam int REG_ADDRESS_LEN = 4;
	localparam int EXE_CMD_LEN     = 4;

	// alu command, as produced by decode
	typedef enum logic [EXE_CMD_LEN-1:0] {
		MOV = 4'b0001,
		MVN = 4'b1001,
		ADD = 4'b0010,
		ADC = 4'b0011,
		SUB = 4'b0100,
		SBC = 4'b0101,
		AND = 4'b0110,
		ORR = 4'b0111,
		EOR = 4'b1000
	} exe_cmd_t;

	typedef enum logic [1:0] {
		LSL = 2'b00,
		LSR = 2'b01,
		ASR = 2'b10,
		ROR = 2'b11
	} shift_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} status_t;

	// 32-bit immediate form, imm8 rotated right by 2 * rotate_imm
	typedef struct packed {
		logic [3:0] rotate_imm;
		logic [7:0] imm8;
	} imm_form_t;

	// immediate-shifted register form
	typedef struct packed {
		logic [4:0] shift_imm;
		shift_t     shift;
		logic       zero;
		logic [3:0] rm;
	} reg_form_t;

	typedef union packed {
		imm_form_t imm_form;
		reg_form_t reg_form;
	} shifter_operand_u;

	typedef struct packed {
		logic wb_en;
		logic mem_r_en;
		logic mem_w_en;
		logic status_w_en;
		logic branch_taken;
	} ex_ctrl_t;

	typedef struct packed {
		logic [ADDRESS_LEN-1:0]     pc;
		ex_ctrl_t                   ctrl;
		logic                       immd;
		exe_cmd_t                   exe_cmd;
		logic                       is_mul;
		logic [REGISTER_LEN-1:0]    val_rn;
		logic [REGISTER_LEN-1:0]    val_rm;
		logic [REG_ADDRESS_LEN-1:0] dest;
		logic [23:0]                signed_immd_24;
		shifter_operand_u           shift_operand;
	} id_ex_t;

	typedef struct packed {
		logic                       wb_en;
		logic                       mem_r_en;
		logic                       mem_w_en;
		logic                       branch_taken;
		logic [REGISTER_LEN-1:0]    alu_res;
		logic [REGISTER_LEN-1:0]    val_rm;
		logic [REG_ADDRESS_LEN-1:0] dest;
	} ex_mem_t;

endpackage

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input  logic                               clk,
	input  logic                               reset,
	input  ex_pkg::id_ex_t                     id_ex,
	input  ex_pkg::status_t                    status_in,
	output ex_pkg::ex_mem_t                    ex_mem,
	output ex_pkg::status_t                    status_out,
	output logic                               status_w_en,
	output logic [ex_pkg::ADDRESS_LEN-1:0]     branch_address,
	output logic                               hazard_wb_en,
	output logic [ex_pkg::REG_ADDRESS_LEN-1:0] hazard_dest
);

	ex_pkg::ex_mem_t ex_next;

	// hazard unit sees the instruction now in execute
	assign hazard_wb_en = id_ex.ctrl.wb_en;
	assign hazard_dest = id_ex.dest;

	exec_unit u_exec_unit (
		.id_ex          (id_ex),
		.status_in      (status_in),
		.ex_next        (ex_next),
		.status_out     (status_out),
		.status_w_en    (status_w_en),
		.branch_address (branch_address)
	);

	ex_mem_reg u_ex_mem_reg (
		.clk     (clk),
		.reset   (reset),
		.ex_next (ex_next),
		.ex_mem  (ex_mem)
	);

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  ex_pkg::id_ex_t                  id_ex,
	input  ex_pkg::status_t                 status_in,
	output ex_pkg::ex_mem_t                 ex_next,
	output ex_pkg::status_t                 status_out,
	output logic                            status_w_en,
	output logic [ex_pkg::ADDRESS_LEN-1:0]  branch_address
);

	logic                            mem_access;
	logic [ex_pkg::REGISTER_LEN-1:0] op2;
	logic [ex_pkg::REGISTER_LEN-1:0] alu_result;
	ex_pkg::status_t                 alu_status;
	logic [ex_pkg::REGISTER_LEN-1:0] mul_result;
	logic [ex_pkg::REGISTER_LEN-1:0] exe_result;
	logic [ex_pkg::ADDRESS_LEN-1:0]  branch_offset;

	assign mem_access = id_ex.ctrl.mem_r_en | id_ex.ctrl.mem_w_en;

	operand2_gen u_operand2_gen (
		.shift_operand (id_ex.shift_operand),
		.immd          (id_ex.immd),
		.mem_access    (mem_access),
		.val_rm        (id_ex.val_rm),
		.op2           (op2)
	);

	ex_alu u_ex_alu (
		.exe_cmd    (id_ex.exe_cmd),
		.a          (id_ex.val_rn),
		.b          (op2),
		.status_in  (status_in),
		.result     (alu_result),
		.status_out (alu_status)
	);

	// low word of the product only
	assign mul_result = id_ex.val_rn * id_ex.val_rm;

	assign exe_result = id_ex.is_mul ? mul_result : alu_result;

	// multiply keeps c and v
	always_comb begin
		status_out = alu_status;
		if (id_ex.is_mul) begin
			status_out.n = mul_result[ex_pkg::REGISTER_LEN-1];
			status_out.z = (mul_result == '0);
			status_out.c = status_in.c;
			status_out.v = status_in.v;
		end
	end

	assign status_w_en = id_ex.ctrl.status_w_en;

	// word offset, sign extended
	assign branch_offset = {{(ex_pkg::ADDRESS_LEN-26){id_ex.signed_immd_24[23]}},
		id_ex.signed_immd_24, 2'b00};
	assign branch_address = id_ex.pc + branch_offset;

	assign ex_next.wb_en        = id_ex.ctrl.wb_en;
	assign ex_next.mem_r_en     = id_ex.ctrl.mem_r_en;
	assign ex_next.mem_w_en     = id_ex.ctrl.mem_w_en;
	assign ex_next.branch_taken = id_ex.ctrl.branch_taken;
	assign ex_next.alu_res      = exe_result;
	assign ex_next.val_rm       = id_ex.val_rm;
	assign ex_next.dest         = id_ex.dest;

endmodule

// File: hw/operand2_gen.sv
`timescale 1ns/1ps

module operand2_gen (
	input  ex_pkg::shifter_operand_u          shift_operand,
	input  logic                              immd,
	input  logic                              mem_access,
	input  logic [ex_pkg::REGISTER_LEN-1:0]   val_rm,
	output logic [ex_pkg::REGISTER_LEN-1:0]   op2
);

	logic [ex_pkg::REGISTER_LEN-1:0] imm_op;
	logic [ex_pkg::REGISTER_LEN-1:0] reg_op;
	logic [ex_pkg::REGISTER_LEN-1:0] mem_op;
	logic [ex_pkg::REGISTER_LEN-1:0] imm8_ext;
	logic [4:0]                      rot_amount;
	logic [4:0]                      shift_amount;

	// rotate by 0 leaves the value as is
	function automatic logic [ex_pkg::REGISTER_LEN-1:0] rotate_right(
		input logic [ex_pkg::REGISTER_LEN-1:0] value,
		input logic [4:0]                      amount
	);
		logic [2*ex_pkg::REGISTER_LEN-1:0] doubled;
		doubled = {value, value} >> amount;
		return doubled[ex_pkg::REGISTER_LEN-1:0];
	endfunction

	assign imm8_ext = {{(ex_pkg::REGISTER_LEN-8){1'b0}}, shift_operand.imm_form.imm8};
	assign rot_amount = {shift_operand.imm_form.rotate_imm, 1'b0};
	assign shift_amount = shift_operand.reg_form.shift_imm;

	// rotated immediate
	assign imm_op = rotate_right(imm8_ext, rot_amount);

	// load/store offset is the raw 12-bit field
	assign mem_op = {{(ex_pkg::REGISTER_LEN-12){1'b0}}, shift_operand};

	// register shifted by an immediate amount
	always_comb begin
		reg_op = val_rm;
		case (shift_operand.reg_form.shift)
			ex_pkg::LSL: begin
				reg_op = val_rm << shift_amount;
			end
			ex_pkg::LSR: begin
				reg_op = val_rm >> shift_amount;
			end
			ex_pkg::ASR: begin
				// sign fill
				reg_op = $signed(val_rm) >>> shift_amount;
			end
			ex_pkg::ROR: begin
				reg_op = rotate_right(val_rm, shift_amount);
			end
			default: begin
				reg_op = val_rm;
			end
		endcase
	end

	always_comb begin
		if (immd) begin
			op2 = imm_op;
		end else if (mem_access) begin
			op2 = mem_op;
		end else begin
			op2 = reg_op;
		end
	end

endmodule
